// ==== zhxpu.f ====
hdl/zhxpu_pkg.sv
hdl/flash_ctrl.sv
hdl/bootloader.sv
hdl/unified_ram.sv
hdl/register_file.sv
hdl/alu.sv
hdl/cpu_core.sv
hdl/dig_ctrl.sv
hdl/zhxpu.sv
verif/flash_model.sv
verif/tb_zhxpu.sv

// ==== run.sh ====
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module tb_zhxpu \
	-f zhxpu.f --Mdir obj_dir -o sim_zhxpu
./obj_dir/sim_zhxpu | tee sim.log

if grep -q "Done: errors found" sim.log; then
	exit 1
fi
if ! grep -q "Done: no errors" sim.log; then
	exit 1
fi
exit 0

// ==== verif/tb_zhxpu.sv ====
`timescale 1ns/1ns

module tb_zhxpu;
	import zhxpu_pkg::*;

	localparam int BOOT_WORDS = 64;
	localparam int FLASH_WAIT = 3;
	localparam int BOOT_TIME = BOOT_WORDS * (FLASH_WAIT + 3);
	localparam int DWELL = 16;

	logic        clk = 1'b0;
	logic        rst = 1'b1;
	flash_addr_t flash_addr;
	word_t       flash_data;
	logic        flash_ce;
	logic        flash_oe;
	logic [6:0]  seg1;
	logic [6:0]  seg2;
	word_t       led;
	logic        boot_done;
	logic        halted;

	int    assert_errors = 0;
	int    check_errors = 0;
	word_t exp_led [$];
	int    exp_count = 0;
	int    model_cycles = 0;
	logic  model_ready = 1'b0;
	int    access_cnt = 0;
	int    boot_cycles = 0;
	int    led_idx = 0;
	logic  ce_q = 1'b1;
	word_t led_q = '0;

	always #10 clk = ~clk;

	zhxpu #(.BOOT_WORDS(BOOT_WORDS), .FLASH_WAIT(FLASH_WAIT)) u_dut (
		.raw_clk(clk),
		.rst(rst),
		.flash_addr(flash_addr),
		.flash_data(flash_data),
		.flash_ce(flash_ce),
		.flash_oe(flash_oe),
		.seg1(seg1),
		.seg2(seg2),
		.led(led),
		.boot_done(boot_done),
		.halted(halted)
	);

	flash_model #(.WORDS(BOOT_WORDS)) u_flash (
		.flash_addr(flash_addr),
		.flash_ce(flash_ce),
		.flash_oe(flash_oe),
		.flash_data(flash_data)
	);

	// Active-low digit from the usual gfedcba hex table
	function automatic logic [6:0] hex_segments(input logic [3:0] d);
		logic [6:0] on;
		case (d)
			4'h0: on = 7'h3f;
			4'h1: on = 7'h06;
			4'h2: on = 7'h5b;
			4'h3: on = 7'h4f;
			4'h4: on = 7'h66;
			4'h5: on = 7'h6d;
			4'h6: on = 7'h7d;
			4'h7: on = 7'h07;
			4'h8: on = 7'h7f;
			4'h9: on = 7'h6f;
			4'ha: on = 7'h77;
			4'hb: on = 7'h7c;
			4'hc: on = 7'h39;
			4'hd: on = 7'h5e;
			4'he: on = 7'h79;
			default: on = 7'h71;
		endcase
		return ~on;
	endfunction

	// Instruction-level model of the program that collects every LED store
	task automatic build_expected();
		word_t     r [8];
		word_t     mem [256];
		mem_addr_t pc;
		mem_addr_t npc;
		word_t     inst;
		logic      done;
		int        steps;
		for (int i = 0; i < 8; i++)
			r[i] = '0;
		for (int i = 0; i < 256; i++)
			mem[i] = (i < BOOT_WORDS) ? u_flash.rom[i] : 16'h0;
		pc = '0;
		done = 1'b0;
		steps = 0;
		while (!done && steps < 1000) begin
			inst = mem[pc];
			npc = pc + 8'd1;
			model_cycles += 2;
			case (inst[15:12])
				ADDU: r[inst[11:9]] = r[inst[8:6]] + r[inst[5:3]];
				SUBU: r[inst[11:9]] = r[inst[8:6]] - r[inst[5:3]];
				AND_OP: r[inst[11:9]] = r[inst[8:6]] & r[inst[5:3]];
				OR_OP: r[inst[11:9]] = r[inst[8:6]] | r[inst[5:3]];
				LI: r[inst[11:9]] = {8'h00, inst[7:0]};
				LW: begin
					r[inst[11:9]] = mem[r[inst[8:6]][7:0]];
					model_cycles += 1;
				end
				SW: begin
					if (r[inst[8:6]][7:0] == LED_ADDR)
						exp_led.push_back(r[inst[5:3]]);
					else
						mem[r[inst[8:6]][7:0]] = r[inst[5:3]];
				end
				BEQZ: if (r[inst[8:6]] == '0) npc = pc + 8'd1 + inst[7:0];
				HALT: done = 1'b1;
				default: ;
			endcase
			pc = npc;
			steps++;
		end
		exp_count = exp_led.size();
	endtask

	task automatic pulse_reset();
		rst <= 1'b1;
		repeat (3) @(posedge clk);
		rst <= 1'b0;
	endtask

	always @(posedge clk) begin
		ce_q <= flash_ce;
		led_q <= led;
		if (rst) begin
			access_cnt <= 0;
			boot_cycles <= 0;
			led_idx <= 0;
		end else begin
			if (ce_q && !flash_ce)
				access_cnt <= access_cnt + 1;
			if (!boot_done)
				boot_cycles <= boot_cycles + 1;
			if (led != led_q)
				led_idx <= led_idx + 1;
		end
	end

	boot_count: assert property (@(posedge clk) disable iff (rst)
		$rose(boot_done) |-> access_cnt == BOOT_WORDS && boot_cycles <= BOOT_TIME + 2)
		else begin
			assert_errors++;
			$display("FAIL boot_done after 0x%h accesses and 0x%h cycles",
				$sampled(access_cnt), $sampled(boot_cycles));
		end

	// Flash words are read in order from address zero
	boot_addr_order: assert property (@(posedge clk) disable iff (rst)
		$fell(flash_ce) |-> flash_addr == flash_addr_t'(access_cnt))
		else begin
			assert_errors++;
			$display("FAIL flash_addr got 0x%h expected 0x%h",
				$sampled(flash_addr), $sampled(access_cnt));
		end

	boot_digits: assert property (@(posedge clk) disable iff (rst)
		!boot_done |-> seg1 == hex_segments(u_dut.init_addr[7:4]) &&
			seg2 == hex_segments(u_dut.init_addr[3:0]))
		else begin
			assert_errors++;
			$display("FAIL seg1/seg2 got 0x%h/0x%h for init_addr 0x%h",
				$sampled(seg1), $sampled(seg2), $sampled(u_dut.init_addr));
		end

	led_value: assert property (@(posedge clk) disable iff (rst)
		$changed(led) |-> led_idx < exp_count && led == exp_led[led_idx])
		else begin
			assert_errors++;
			$display("FAIL led got 0x%h expected 0x%h at store %0d",
				$sampled(led), exp_led[$sampled(led_idx)], $sampled(led_idx));
		end

	halt_sequence: assert property (@(posedge clk) disable iff (rst)
		$rose(halted) |-> led_idx == exp_count)
		else begin
			assert_errors++;
			$display("Core halted after %0d of %0d LED stores", $sampled(led_idx), exp_count);
		end

	halt_frozen: assert property (@(posedge clk) disable iff (rst)
		halted |=> $stable(u_dut.pc) && $stable(seg1) && $stable(seg2) && $stable(led))
		else begin
			assert_errors++;
			$display("FAIL pc 0x%h led 0x%h moved after halt", $sampled(u_dut.pc),
				$sampled(led));
		end

	reset_clears: assert property (@(posedge clk)
		rst |=> !halted && !boot_done && led == '0 && flash_ce && flash_oe)
		else begin
			assert_errors++;
			$display("FAIL led 0x%h halted 0x%h boot_done 0x%h after reset",
				$sampled(led), $sampled(halted), $sampled(boot_done));
		end

	initial begin
		int limit;
		wait (model_ready);
		limit = 2 * (BOOT_TIME + 2) + 2 * model_cycles + 2 * DWELL + 64;
		repeat (limit) @(posedge clk);
		$display("Timeout: the core did not halt within %0d cycles", limit);
		$display("Done: errors found");
		$finish;
	end

	initial begin
		@(posedge clk);
		build_expected();
		model_ready = 1'b1;
		if (exp_count == 0) begin
			check_errors++;
			$display("Reference model found no LED stores in the program");
		end
		repeat (2) @(posedge clk);
		rst <= 1'b0;

		// First run is cut short by a reset in the middle of the program
		while (led_idx < 4)
			@(posedge clk);
		pulse_reset();

		while (!halted)
			@(posedge clk);
		repeat (DWELL) @(posedge clk);
		if (led_idx != exp_count) begin
			check_errors++;
			$display("LED sequence ended after %0d of %0d stores", led_idx, exp_count);
		end

		$display("errors: assertions %0d, checks %0d", assert_errors, check_errors);
		if (assert_errors == 0 && check_errors == 0)
			$display("Done: no errors");
		else
			$display("Done: errors found");
		$finish;
	end

endmodule

// ==== verif/flash_model.sv ====
`timescale 1ns/1ns

module flash_model #(
	parameter int WORDS     = 64,
	parameter int ACCESS_NS = 45
) (
	input  zhxpu_pkg::flash_addr_t flash_addr,
	input  logic                   flash_ce,
	input  logic                   flash_oe,
	output zhxpu_pkg::word_t       flash_data
);
	import zhxpu_pkg::*;

	word_t rom [WORDS];

	// Unprogrammed words fold every address bit into a HALT word
	function automatic word_t fill_word(input flash_addr_t a);
		return {4'hf, 12'(a) ^ 12'(a >> 12)};
	endfunction

	function automatic word_t read_word(input flash_addr_t a);
		if (a < flash_addr_t'(WORDS))
			return rom[a[$clog2(WORDS)-1:0]];
		return fill_word(a);
	endfunction

	initial begin
		for (int i = 0; i < WORDS; i++)
			rom[i] = fill_word(flash_addr_t'(i));
		rom[0]  = 16'h425a; // li r1, 0x5a
		rom[1]  = 16'h440f; // li r2, 0x0f
		rom[2]  = 16'h4eff; // li r7, led address
		rom[3]  = 16'h0650; // addu r3, r1, r2
		rom[4]  = 16'h61d8; // sw r3 -> (r7)
		rom[5]  = 16'h1650; // subu r3, r1, r2
		rom[6]  = 16'h61d8;
		rom[7]  = 16'h2650; // and r3, r1, r2
		rom[8]  = 16'h61d8;
		rom[9]  = 16'h3650; // or r3, r1, r2
		rom[10] = 16'h61d8;
		rom[11] = 16'h4880; // li r4, 0x80
		rom[12] = 16'h6108; // sw r1 -> (r4)
		rom[13] = 16'h5b00; // lw r5, (r4)
		rom[14] = 16'h61e8; // sw r5 -> (r7)
		rom[15] = 16'h4805; // li r4, 5
		rom[16] = 16'h4201; // li r1, 1
		rom[17] = 16'h4600; // li r3, 0
		rom[18] = 16'h61e0; // loop: sw r4 -> (r7)
		rom[19] = 16'h1908; // subu r4, r4, r1
		rom[20] = 16'h7101; // beqz r4, +1
		rom[21] = 16'h70fc; // beqz r3, loop
		rom[22] = 16'hf000; // halt
	end

	// Output is only valid with chip and output enable low
	assign #(ACCESS_NS) flash_data = (!flash_ce && !flash_oe) ? read_word(flash_addr) : 16'hxxxx;

endmodule

// ==== hdl/zhxpu.sv ====
`timescale 1ns/1ns

module zhxpu #(
	parameter int BOOT_WORDS = 64,
	parameter int FLASH_WAIT = 3
) (
	input  logic                   raw_clk,
	input  logic                   rst,
	output zhxpu_pkg::flash_addr_t flash_addr,
	input  zhxpu_pkg::word_t       flash_data,
	output logic                   flash_ce,
	output logic                   flash_oe,
	output logic [6:0]             seg1,
	output logic [6:0]             seg2,
	output zhxpu_pkg::word_t       led,
	output logic                   boot_done,
	output logic                   halted
);
	import zhxpu_pkg::*;

	logic        flash_read_ctrl;
	logic        flash_ready;
	flash_addr_t mflash_addr;
	word_t       mflash_data;
	logic        init_we;
	mem_addr_t   init_addr;
	word_t       init_data;
	mem_addr_t   mem_addr;
	word_t       mem_wdata;
	logic        mem_we;
	word_t       rdata;
	mem_addr_t   pc;
	logic [3:0]  dig1_data;
	logic [3:0]  dig2_data;

	flash_ctrl #(.FLASH_WAIT(FLASH_WAIT)) u_flash_ctrl (
		.raw_clk(raw_clk),
		.rst(rst),
		.addr(mflash_addr),
		.read_ctrl(flash_read_ctrl),
		.flash_addr(flash_addr),
		.flash_data(flash_data),
		.flash_ce(flash_ce),
		.flash_oe(flash_oe),
		.data(mflash_data),
		.flash_ready(flash_ready)
	);

	bootloader #(.BOOT_WORDS(BOOT_WORDS)) u_bootloader (
		.raw_clk(raw_clk),
		.rst(rst),
		.flash_ready(flash_ready),
		.flash_data(mflash_data),
		.read_ctrl(flash_read_ctrl),
		.caddr(mflash_addr),
		.write_ctrl(init_we),
		.init_addr(init_addr),
		.init_data(init_data),
		.boot_done(boot_done)
	);

	unified_ram u_ram (
		.raw_clk(raw_clk),
		.boot_done(boot_done),
		.init_addr(init_addr),
		.init_data(init_data),
		.init_we(init_we),
		.mem_addr(mem_addr),
		.mem_wdata(mem_wdata),
		.mem_we(mem_we),
		.rdata(rdata)
	);

	cpu_core u_core (
		.raw_clk(raw_clk),
		.rst(rst),
		.boot_done(boot_done),
		.mem_addr(mem_addr),
		.mem_wdata(mem_wdata),
		.mem_we(mem_we),
		.rdata(rdata),
		.pc(pc),
		.led(led),
		.halted(halted)
	);

	// Copy address while booting, pc once running
	assign dig1_data = boot_done ? pc[7:4] : init_addr[7:4];
	assign dig2_data = boot_done ? pc[3:0] : init_addr[3:0];

	dig_ctrl u_dig_ctrl_1 (
		.dig(dig1_data),
		.light(seg1)
	);

	dig_ctrl u_dig_ctrl_2 (
		.dig(dig2_data),
		.light(seg2)
	);

endmodule

// ==== hdl/dig_ctrl.sv ====
`timescale 1ns/1ns

module dig_ctrl (
	input  logic [3:0] dig,
	output logic [6:0] light
);
	// Active low, bit order g f e d c b a
	always_comb begin
		case (dig)
			4'h0: light = 7'b1000000;
			4'h1: light = 7'b1111001;
			4'h2: light = 7'b0100100;
			4'h3: light = 7'b0110000;
			4'h4: light = 7'b0011001;
			4'h5: light = 7'b0010010;
			4'h6: light = 7'b0000010;
			4'h7: light = 7'b1111000;
			4'h8: light = 7'b0000000;
			4'h9: light = 7'b0010000;
			4'ha: light = 7'b0001000;
			4'hb: light = 7'b0000011;
			4'hc: light = 7'b1000110;
			4'hd: light = 7'b0100001;
			4'he: light = 7'b0000110;
			default: light = 7'b0001110;
		endcase
	end

endmodule

// ==== hdl/cpu_core.sv ====
`timescale 1ns/1ns

module cpu_core (
	input  logic                 raw_clk,
	input  logic                 rst,
	input  logic                 boot_done,
	output zhxpu_pkg::mem_addr_t mem_addr,
	output zhxpu_pkg::word_t     mem_wdata,
	output logic                 mem_we,
	input  zhxpu_pkg::word_t     rdata,
	output zhxpu_pkg::mem_addr_t pc,
	output zhxpu_pkg::word_t     led,
	output logic                 halted
);
	import zhxpu_pkg::*;

	typedef enum logic [2:0] {S_BOOT, S_FETCH, S_EXEC, S_LOAD, S_HALT} state_t;

	state_t    state;
	word_t     ir;
	word_t     inst;
	opcode_t   op;
	word_t     rs_val;
	word_t     rt_val;
	word_t     alu_op2;
	word_t     alu_res;
	logic      alu_zero;
	logic      exec;
	logic      mem_op;
	logic      reg_we;
	word_t     reg_wval;
	mem_addr_t pc_next;

	// Instruction shows up on rdata in EXEC, ir keeps it for LOAD
	assign inst = (state == S_EXEC) ? rdata : ir;
	assign op = inst_op(inst);
	assign exec = (state == S_EXEC);
	assign mem_op = exec && (op == LW || op == SW);

	assign alu_op2 = (op == LI) ? word_t'(inst_imm(inst)) : rt_val;

	register_file u_regs (
		.raw_clk(raw_clk),
		.rst(rst),
		.read_addr1(inst_rs(inst)),
		.read_value1(rs_val),
		.read_addr2(inst_rt(inst)),
		.read_value2(rt_val),
		.write_en(reg_we),
		.write_addr(inst_rd(inst)),
		.write_value(reg_wval)
	);

	alu u_alu (
		.opn(op),
		.op1(rs_val),
		.op2(alu_op2),
		.res(alu_res),
		.zero(alu_zero)
	);

	assign reg_we = (exec && op inside {ADDU, SUBU, AND_OP, OR_OP, LI}) || (state == S_LOAD);
	assign reg_wval = (state == S_LOAD) ? rdata : alu_res;

	assign mem_addr = mem_op ? rs_val[7:0] : pc;
	assign mem_wdata = rt_val;
	assign mem_we = exec && op == SW && mem_addr != LED_ADDR;

	// Offset is relative to the next pc
	assign pc_next = (op == BEQZ && alu_zero) ? pc + 8'd1 + inst_imm(inst) : pc + 8'd1;

	always_ff @(posedge raw_clk) begin
		if (rst) begin
			state <= S_BOOT;
			pc <= '0;
			led <= '0;
			halted <= 1'b0;
		end else begin
			case (state)
				S_BOOT: if (boot_done) state <= S_FETCH;
				S_FETCH: state <= S_EXEC;
				S_EXEC: begin
					if (op == HALT) begin
						halted <= 1'b1;
						state <= S_HALT;
					end else begin
						pc <= pc_next;
						state <= (op == LW) ? S_LOAD : S_FETCH;
					end
					if (op == SW && mem_addr == LED_ADDR)
						led <= rt_val;
				end
				S_LOAD: state <= S_FETCH;
				S_HALT: state <= S_HALT;
				default: state <= S_BOOT;
			endcase
		end
	end

	always_ff @(posedge raw_clk) begin
		if (exec)
			ir <= rdata;
	end

endmodule

// ==== hdl/alu.sv ====
`timescale 1ns/1ns

module alu (
	input  zhxpu_pkg::opcode_t opn,
	input  zhxpu_pkg::word_t   op1,
	input  zhxpu_pkg::word_t   op2,
	output zhxpu_pkg::word_t   res,
	output logic               zero
);
	import zhxpu_pkg::*;

	always_comb begin
		case (opn)
			ADDU:    res = op1 + op2;
			SUBU:    res = op1 - op2;
			AND_OP:  res = op1 & op2;
			OR_OP:   res = op1 | op2;
			// Immediate comes in on op2
			LI:      res = op2;
			// Pass rs so zero serves the branch test
			default: res = op1;
		endcase
	end

	assign zero = (res == '0);

endmodule

// ==== hdl/register_file.sv ====
`timescale 1ns/1ns

module register_file (
	input  logic                 raw_clk,
	input  logic                 rst,
	input  zhxpu_pkg::reg_addr_t read_addr1,
	output zhxpu_pkg::word_t     read_value1,
	input  zhxpu_pkg::reg_addr_t read_addr2,
	output zhxpu_pkg::word_t     read_value2,
	input  logic                 write_en,
	input  zhxpu_pkg::reg_addr_t write_addr,
	input  zhxpu_pkg::word_t     write_value
);
	import zhxpu_pkg::*;

	word_t regs [NUM_REGS];

	assign read_value1 = regs[read_addr1];
	assign read_value2 = regs[read_addr2];

	always_ff @(posedge raw_clk) begin
		if (rst) begin
			for (int i = 0; i < NUM_REGS; i++)
				regs[i] <= '0;
		end else if (write_en) begin
			regs[write_addr] <= write_value;
		end
	end

endmodule

// ==== hdl/unified_ram.sv ====
`timescale 1ns/1ns

module unified_ram (
	input  logic                 raw_clk,
	input  logic                 boot_done,
	input  zhxpu_pkg::mem_addr_t init_addr,
	input  zhxpu_pkg::word_t     init_data,
	input  logic                 init_we,
	input  zhxpu_pkg::mem_addr_t mem_addr,
	input  zhxpu_pkg::word_t     mem_wdata,
	input  logic                 mem_we,
	output zhxpu_pkg::word_t     rdata
);
	import zhxpu_pkg::*;

	localparam int DEPTH = 2 ** $bits(mem_addr_t);

	word_t     mem [DEPTH];
	mem_addr_t sel_addr;
	word_t     sel_data;
	logic      sel_we;

	// Boot writer owns the port until boot_done
	assign sel_addr = boot_done ? mem_addr : init_addr;
	assign sel_data = boot_done ? mem_wdata : init_data;
	assign sel_we = boot_done ? mem_we : init_we;

	always_ff @(posedge raw_clk) begin
		if (sel_we)
			mem[sel_addr] <= sel_data;
		rdata <= mem[sel_addr];
	end

endmodule

// ==== hdl/bootloader.sv ====
`timescale 1ns/1ns

module bootloader #(
	parameter int BOOT_WORDS = 64
) (
	input  logic                   raw_clk,
	input  logic                   rst,
	input  logic                   flash_ready,
	input  zhxpu_pkg::word_t       flash_data,
	output logic                   read_ctrl,
	output zhxpu_pkg::flash_addr_t caddr,
	output logic                   write_ctrl,
	output zhxpu_pkg::mem_addr_t   init_addr,
	output zhxpu_pkg::word_t       init_data,
	output logic                   boot_done
);
	import zhxpu_pkg::*;

	typedef enum logic [1:0] {S_START, S_WAIT, S_WRITE, S_DONE} state_t;

	state_t    state;
	mem_addr_t word_cnt;

	assign caddr = flash_addr_t'(word_cnt);
	assign init_addr = word_cnt;

	always_ff @(posedge raw_clk) begin
		if (rst) begin
			state <= S_START;
			word_cnt <= '0;
			read_ctrl <= 1'b0;
			write_ctrl <= 1'b0;
			boot_done <= 1'b0;
		end else begin
			read_ctrl <= 1'b0;
			write_ctrl <= 1'b0;
			case (state)
				S_START: begin
					read_ctrl <= 1'b1;
					state <= S_WAIT;
				end
				S_WAIT: begin
					if (flash_ready) begin
						write_ctrl <= 1'b1;
						state <= S_WRITE;
					end
				end
				S_WRITE: begin
					if (word_cnt == mem_addr_t'(BOOT_WORDS - 1)) begin
						boot_done <= 1'b1;
						state <= S_DONE;
					end else begin
						// Next word, address moves with the request
						word_cnt <= word_cnt + 1'b1;
						read_ctrl <= 1'b1;
						state <= S_WAIT;
					end
				end
				default: state <= S_DONE;
			endcase
		end
	end

	always_ff @(posedge raw_clk) begin
		if (state == S_WAIT && flash_ready)
			init_data <= flash_data;
	end

endmodule

// ==== hdl/flash_ctrl.sv ====
`timescale 1ns/1ns

module flash_ctrl #(
	parameter int FLASH_WAIT = 3
) (
	input  logic                   raw_clk,
	input  logic                   rst,
	input  zhxpu_pkg::flash_addr_t addr,
	input  logic                   read_ctrl,
	output zhxpu_pkg::flash_addr_t flash_addr,
	input  zhxpu_pkg::word_t       flash_data,
	output logic                   flash_ce,
	output logic                   flash_oe,
	output zhxpu_pkg::word_t       data,
	output logic                   flash_ready
);
	localparam int CW = $clog2(FLASH_WAIT + 1);

	logic [CW-1:0] wait_cnt;
	logic          busy;
	logic          last;

	// Chip enable low means an access is in progress
	assign busy = ~flash_ce;
	assign last = busy && (wait_cnt == '0);

	always_ff @(posedge raw_clk) begin
		if (rst) begin
			flash_ce <= 1'b1;
			flash_oe <= 1'b1;
			flash_ready <= 1'b0;
			wait_cnt <= '0;
		end else begin
			flash_ready <= 1'b0;
			if (!busy && read_ctrl) begin
				flash_ce <= 1'b0;
				flash_oe <= 1'b0;
				wait_cnt <= CW'(FLASH_WAIT - 1);
			end else if (last) begin
				flash_ce <= 1'b1;
				flash_oe <= 1'b1;
				flash_ready <= 1'b1;
			end else if (busy) begin
				wait_cnt <= wait_cnt - 1'b1;
			end
		end
	end

	always_ff @(posedge raw_clk) begin
		if (!busy && read_ctrl)
			flash_addr <= addr;
		// Sample at the end of the access window
		if (last)
			data <= flash_data;
	end

endmodule

// ==== hdl/zhxpu_pkg.sv ====
package zhxpu_pkg;

	typedef logic [15:0] word_t;
	typedef logic [2:0] reg_addr_t;
	typedef logic [7:0] mem_addr_t;
	typedef logic [22:0] flash_addr_t;

	typedef enum logic [3:0] {
		ADDU   = 4'h0,
		SUBU   = 4'h1,
		AND_OP = 4'h2,
		OR_OP  = 4'h3,
		LI     = 4'h4,
		LW     = 4'h5,
		SW     = 4'h6,
		BEQZ   = 4'h7,
		HALT   = 4'hf
	} opcode_t;

	localparam int NUM_REGS = 8;

	// Stores here go to the LED register, not RAM
	localparam mem_addr_t LED_ADDR = 8'd255;

	// Instruction fields
	function automatic opcode_t inst_op(input word_t inst);
		return opcode_t'(inst[15:12]);
	endfunction

	function automatic reg_addr_t inst_rd(input word_t inst);
		return inst[11:9];
	endfunction

	function automatic reg_addr_t inst_rs(input word_t inst);
		return inst[8:6];
	endfunction

	function automatic reg_addr_t inst_rt(input word_t inst);
		return inst[5:3];
	endfunction

	function automatic logic [7:0] inst_imm(input word_t inst);
		return inst[7:0];
	endfunction

endpackage
